//--- id_pkg.sv
// id stage package, rv field widths and decode enums
package id_pkg;

  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_NUM     = 32;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    ALU_PASS_B, // lui
    ALU_LINK    // pc + 4
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
    BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_func_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  typedef enum logic {
    SRC2_RS2,
    SRC2_IMM
  } src2_sel_e;

endpackage

//--- gpr_file.sv
// general register file, 32 x XLEN, two read ports and one write port
module gpr_file import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  input  logic                   i_wen,
  input  logic [GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2
);

  logic [XLEN-1:0] regs [GPR_NUM];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  a_x0_reads_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((i_raddr1 == '0) |-> (o_rdata1 == '0)) and ((i_raddr2 == '0) |-> (o_rdata2 == '0)));

endmodule

//--- operand_fwd.sv
// operand read with execute/memory/writeback forwarding
module operand_fwd import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_rs2,
  input  logic                   i_wb_wen,
  input  logic [GPR_ADDR_WD-1:0] i_wb_addr,
  input  logic [XLEN-1:0]        i_wb_data,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data
);

  logic [XLEN-1:0] rf_rdata1;
  logic [XLEN-1:0] rf_rdata2;

  // newest stage wins, rd 0 never forwards
  function automatic logic [XLEN-1:0] pick(input logic [GPR_ADDR_WD-1:0] rs,
                                           input logic [XLEN-1:0]        rf_data);
    if (i_es_rd != '0 && i_es_rd == rs) return i_es_result;
    if (i_ms_rd != '0 && i_ms_rd == rs) return i_ms_result;
    if (i_ws_rd != '0 && i_ws_rd == rs) return i_ws_result;
    return rf_data;
  endfunction

  always_comb begin
    o_rs1_data = pick(i_rs1, rf_rdata1);
    o_rs2_data = pick(i_rs2, rf_rdata2);
  end

  gpr_file #(.XLEN(XLEN)) u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (i_rs1),
    .i_raddr2 (i_rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

endmodule

//--- inst_decoder.sv
// rv64i decoder, register indices, immediates and control for the held instruction
module inst_decoder import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic [INST_WD-1:0]     i_inst,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output logic                   o_uses_rs2,
  output alu_op_e                o_alu_op,
  output src2_sel_e              o_src2_sel,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output mem_op_e                o_mem_op,
  output logic                   o_load,
  output br_func_e               o_br_func,
  output logic                   o_invalid
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  alu_op_e         alu_f3;
  logic            op_ok;
  logic            shamt_ok;
  logic            use_rs1;
  logic            gpr_wen;
  logic            mem_ren;
  logic            mem_wen;
  br_func_e        br_func;
  logic            invalid;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // only sub and sra carry funct7 = 0100000
  assign op_ok = (funct7 == 7'b0) ||
                 ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
  assign shamt_ok = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b0) :
                    (funct3 == 3'b101) ? ({i_inst[31], i_inst[29:26]} == 5'b0) : 1'b1;

  always_comb begin
    alu_f3 = ALU_ADD;
    case (funct3)
      3'b000: alu_f3 = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001: alu_f3 = ALU_SLL;
      3'b010: alu_f3 = ALU_SLT;
      3'b011: alu_f3 = ALU_SLTU;
      3'b100: alu_f3 = ALU_XOR;
      3'b101: alu_f3 = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110: alu_f3 = ALU_OR;
      3'b111: alu_f3 = ALU_AND;
    endcase
  end

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = ALU_ADD;
    o_src2_sel = SRC2_IMM;
    o_uses_rs2 = 1'b0;
    use_rs1    = 1'b1;
    gpr_wen    = 1'b0;
    mem_ren    = 1'b0;
    mem_wen    = 1'b0;
    br_func    = BR_NONE;
    invalid    = 1'b0;
    case (opcode)
      OPC_OP: begin
        o_alu_op   = alu_f3;
        o_src2_sel = SRC2_RS2;
        o_uses_rs2 = 1'b1;
        gpr_wen    = 1'b1;
        invalid    = !op_ok;
      end
      OPC_OP_IMM: begin
        o_alu_op = alu_f3;
        gpr_wen  = 1'b1;
        invalid  = !shamt_ok;
      end
      OPC_LOAD: begin
        mem_ren = 1'b1;
        gpr_wen = 1'b1;
        invalid = (funct3 == 3'b111);
      end
      OPC_STORE: begin
        o_imm      = imm_s;
        o_uses_rs2 = 1'b1;
        mem_wen    = 1'b1;
        invalid    = funct3[2]; // sb..sd only
      end
      OPC_BRANCH: begin
        o_imm      = imm_b;
        o_src2_sel = SRC2_RS2;
        o_uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  br_func = BR_BEQ;
          3'b001:  br_func = BR_BNE;
          3'b100:  br_func = BR_BLT;
          3'b101:  br_func = BR_BGE;
          3'b110:  br_func = BR_BLTU;
          3'b111:  br_func = BR_BGEU;
          default: invalid = 1'b1;
        endcase
      end
      OPC_JAL: begin
        o_imm    = imm_j;
        o_alu_op = ALU_LINK;
        use_rs1  = 1'b0;
        gpr_wen  = 1'b1;
        br_func  = BR_JAL;
      end
      OPC_JALR: begin
        o_alu_op = ALU_LINK;
        gpr_wen  = 1'b1;
        br_func  = BR_JALR;
        invalid  = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        o_imm    = imm_u;
        o_alu_op = ALU_PASS_B;
        use_rs1  = 1'b0;
        gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm   = imm_u;
        use_rs1 = 1'b0; // execute adds o_pc
        gpr_wen = 1'b1;
      end
      default: begin
        use_rs1 = 1'b0;
        invalid = 1'b1;
      end
    endcase
  end

  assign o_invalid = invalid;
  assign o_gpr_wen = gpr_wen && !invalid;
  assign o_mem_ren = mem_ren && !invalid;
  assign o_mem_wen = mem_wen && !invalid;
  assign o_load    = o_mem_ren;
  assign o_br_func = invalid ? BR_NONE : br_func;
  assign o_mem_op  = mem_op_e'(funct3);
  assign o_rs1     = use_rs1 ? i_inst[19:15] : '0; // u/j imm bits must not stall
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = o_gpr_wen ? i_inst[11:7] : '0; // rd 0 blocks later bypass

  a_mem_excl: assert final (!(o_mem_ren && o_mem_wen));

endmodule

//--- id_stage_ctrl.sv
// decode stage register with valid/allowin handshake and load-use stall
module id_stage_ctrl import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_fs_valid,
  input  logic [INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]        i_fs_pc,
  input  logic                   i_es_allowin,
  input  logic                   i_es_load,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_rs2,
  input  logic                   i_uses_rs2,
  output logic                   o_ds_valid,
  output logic [INST_WD-1:0]     o_ds_inst,
  output logic [XLEN-1:0]        o_ds_pc,
  output logic                   o_load_stall,
  output logic                   o_ds_allowin,
  output logic                   o_ds_to_es_valid
);

  logic rs1_hit;
  logic rs2_hit;

  assign rs1_hit = (i_es_rd == i_rs1);
  assign rs2_hit = i_uses_rs2 && (i_es_rd == i_rs2); // i-type rs2 field is imm

  // load result only exists after mem, so wait one cycle
  assign o_load_stall     = o_ds_valid && i_es_load && (i_es_rd != '0) && (rs1_hit || rs2_hit);
  assign o_ds_to_es_valid = o_ds_valid && !o_load_stall;
  assign o_ds_allowin     = !o_ds_valid || (!o_load_stall && i_es_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      o_ds_inst <= i_fs_inst;
      o_ds_pc   <= i_fs_pc;
    end
  end

  a_no_issue_in_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_ds_to_es_valid && o_load_stall));

endmodule

//--- branch_unit.sv
// branch resolution, condition compare and target address toward fetch
module branch_unit import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            i_ds_valid,
  input  br_func_e        i_br_func,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  input  logic            i_load_stall,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target,
  output logic            o_br_stall
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic [XLEN-1:0] jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      BR_JAL,
      BR_JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum    = i_rs1_data + i_imm;
  assign o_br_target = (i_br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_br_taken  = i_ds_valid && cond;
  assign o_br_stall  = o_br_taken && i_load_stall; // operands not final yet

endmodule

//--- id_stage.sv
// decode stage top, ties together stage control, decoder, forwarding and branch unit
module id_stage import id_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // fetch side
  input  logic                   i_fs_valid,
  input  logic [INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]        i_fs_pc,
  output logic                   o_ds_allowin,
  // execute side
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  // register write port
  input  logic                   i_wb_wen,
  input  logic [GPR_ADDR_WD-1:0] i_wb_addr,
  input  logic [XLEN-1:0]        i_wb_data,
  // bypass
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  input  logic                   i_es_load,
  // decoded instruction
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic [XLEN-1:0]        o_imm,
  output logic [XLEN-1:0]        o_pc,
  output alu_op_e                o_alu_op,
  output src2_sel_e              o_src2_sel,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output mem_op_e                o_mem_op,
  output logic                   o_load,
  output logic                   o_invalid,
  // to fetch
  output logic                   o_br_taken,
  output logic [XLEN-1:0]        o_br_target,
  output logic                   o_br_stall
);

  logic                   ds_valid;
  logic [INST_WD-1:0]     ds_inst;
  logic                   load_stall;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic                   uses_rs2;
  br_func_e               br_func;

  id_stage_ctrl #(.XLEN(XLEN)) u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_es_load        (i_es_load),
    .i_es_rd          (i_es_rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_uses_rs2       (uses_rs2),
    .o_ds_valid       (ds_valid),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (o_pc),
    .o_load_stall     (load_stall),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid)
  );

  inst_decoder #(.XLEN(XLEN)) u_dec (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_rd),
    .o_imm      (o_imm),
    .o_uses_rs2 (uses_rs2),
    .o_alu_op   (o_alu_op),
    .o_src2_sel (o_src2_sel),
    .o_gpr_wen  (o_gpr_wen),
    .o_mem_ren  (o_mem_ren),
    .o_mem_wen  (o_mem_wen),
    .o_mem_op   (o_mem_op),
    .o_load     (o_load),
    .o_br_func  (br_func),
    .o_invalid  (o_invalid)
  );

  operand_fwd #(.XLEN(XLEN)) u_fwd (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_wb_wen    (i_wb_wen),
    .i_wb_addr   (i_wb_addr),
    .i_wb_data   (i_wb_data),
    .i_es_rd     (i_es_rd),
    .i_es_result (i_es_result),
    .i_ms_rd     (i_ms_rd),
    .i_ms_result (i_ms_result),
    .i_ws_rd     (i_ws_rd),
    .i_ws_result (i_ws_result),
    .o_rs1_data  (o_rs1_data),
    .o_rs2_data  (o_rs2_data)
  );

  branch_unit #(.XLEN(XLEN)) u_bru (
    .i_ds_valid   (ds_valid),
    .i_br_func    (br_func),
    .i_rs1_data   (o_rs1_data),
    .i_rs2_data   (o_rs2_data),
    .i_pc         (o_pc),
    .i_imm        (o_imm),
    .i_load_stall (load_stall),
    .o_br_taken   (o_br_taken),
    .o_br_target  (o_br_target),
    .o_br_stall   (o_br_stall)
  );

endmodule

//--- tb_id_stage.sv
// testbench for the decode stage, directed tests on decode, forwarding, stalls and branches
module tb_id_stage import id_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN = 64;
  localparam int MAX_CYCLES = 500; // six tests of at most ~60 cycles, plus margin

  logic                   clk;
  logic                   rst_n;
  logic                   fs_valid;
  logic [INST_WD-1:0]     fs_inst;
  logic [XLEN-1:0]        fs_pc;
  logic                   es_allowin;
  logic                   wb_wen;
  logic [GPR_ADDR_WD-1:0] wb_addr;
  logic [XLEN-1:0]        wb_data;
  logic [GPR_ADDR_WD-1:0] es_rd;
  logic [XLEN-1:0]        es_result;
  logic [GPR_ADDR_WD-1:0] ms_rd;
  logic [XLEN-1:0]        ms_result;
  logic [GPR_ADDR_WD-1:0] ws_rd;
  logic [XLEN-1:0]        ws_result;
  logic                   es_load;
  logic                   ds_allowin;
  logic                   ds_to_es_valid;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic [XLEN-1:0]        imm;
  logic [XLEN-1:0]        pc;
  alu_op_e                alu_op;
  src2_sel_e              src2_sel;
  logic [GPR_ADDR_WD-1:0] rd;
  logic                   gpr_wen;
  logic                   mem_ren;
  logic                   mem_wen;
  mem_op_e                mem_op;
  logic                   load;
  logic                   invalid;
  logic                   br_taken;
  logic [XLEN-1:0]        br_target;
  logic                   br_stall;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [15:0] lfsr_state = 16'd89;
  logic [63:0] gpr_model [32]; // expected register contents

  id_stage #(.XLEN(XLEN)) u_id_stage (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_valid       (fs_valid),
    .i_fs_inst        (fs_inst),
    .i_fs_pc          (fs_pc),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .i_wb_wen         (wb_wen),
    .i_wb_addr        (wb_addr),
    .i_wb_data        (wb_data),
    .i_es_rd          (es_rd),
    .i_es_result      (es_result),
    .i_ms_rd          (ms_rd),
    .i_ms_result      (ms_result),
    .i_ws_rd          (ws_rd),
    .i_ws_result      (ws_result),
    .i_es_load        (es_load),
    .o_rs1_data       (rs1_data),
    .o_rs2_data       (rs2_data),
    .o_imm            (imm),
    .o_pc             (pc),
    .o_alu_op         (alu_op),
    .o_src2_sel       (src2_sel),
    .o_rd             (rd),
    .o_gpr_wen        (gpr_wen),
    .o_mem_ren        (mem_ren),
    .o_mem_wen        (mem_wen),
    .o_mem_op         (mem_op),
    .o_load           (load),
    .o_invalid        (invalid),
    .o_br_taken       (br_taken),
    .o_br_target      (br_target),
    .o_br_stall       (br_stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
    logic signed [63:0] s;
    s = v << (64 - bits);
    return s >>> (64 - bits);
  endfunction

  // rv32 base encodings
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rdst);
    return {f7, rs2, rs1, f3, rdst, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rdst,
                                        input logic [6:0] opc);
    return {imm12, rs1, f3, rdst, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm12, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rdst,
                                        input logic [6:0] opc);
    return {imm20, rdst, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rdst);
    return {off[20], off[10:1], off[11], off[19:12], rdst, 7'b1101111};
  endfunction

  task automatic expect_eq(input string test, input string field,
                           input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // hand one instruction to decode, then hold it there with es_allowin low
  task automatic issue(input logic [31:0] inst, input logic [63:0] at_pc);
    tick();
    es_load    = 1'b0;
    es_rd      = '0;
    ms_rd      = '0;
    ws_rd      = '0;
    fs_valid   = 1'b1;
    fs_inst    = inst;
    fs_pc      = at_pc;
    es_allowin = 1'b1;
    #1;
    while (!ds_allowin) begin
      tick();
      #1;
    end
    tick();
    fs_valid   = 1'b0;
    es_allowin = 1'b0;
    #1;
  endtask

  task automatic write_gpr(input logic [4:0] addr, input logic [63:0] data);
    tick();
    wb_wen  = 1'b1;
    wb_addr = addr;
    wb_data = data;
    tick();
    wb_wen = 1'b0;
    if (addr != 5'd0) gpr_model[addr] = data;
  endtask

  // exp_en is {gpr_wen, mem_ren, mem_wen, load}
  task automatic check_decode(input string t, input logic [31:0] inst, input alu_op_e exp_alu,
                              input src2_sel_e exp_src2, input logic [4:0] exp_rd,
                              input logic has_imm, input logic [63:0] exp_imm,
                              input logic [3:0] exp_en);
    issue(inst, 64'h0000_0000_0001_0000);
    expect_eq(t, "ds_to_es_valid", 1, ds_to_es_valid);
    expect_eq(t, "invalid", 0, invalid);
    expect_eq(t, "alu_op", 64'(exp_alu), 64'(alu_op));
    expect_eq(t, "src2_sel", 64'(exp_src2), 64'(src2_sel));
    expect_eq(t, "rd", 64'(exp_rd), 64'(rd));
    if (has_imm) expect_eq(t, "imm", exp_imm, imm);
    expect_eq(t, "enables", 64'(exp_en), 64'({gpr_wen, mem_ren, mem_wen, load}));
    expect_eq(t, "mem_op", 64'(inst[14:12]), 64'(mem_op));
    expect_eq(t, "pc", 64'h0000_0000_0001_0000, pc);
  endtask

  task automatic check_branch(input string t, input logic [31:0] inst, input logic [63:0] at_pc,
                              input logic exp_taken, input logic [63:0] exp_target);
    issue(inst, at_pc);
    expect_eq(t, "br_taken", 64'(exp_taken), 64'(br_taken));
    expect_eq(t, "br_target", exp_target, br_target);
    expect_eq(t, "br_stall", 0, br_stall);
  endtask

  task automatic test_reset_decode();
    string t;
    t = "reset";
    expect_eq(t, "ds_allowin", 1, ds_allowin);
    expect_eq(t, "ds_to_es_valid", 0, ds_to_es_valid);
    expect_eq(t, "br_taken", 0, br_taken);
    expect_eq(t, "br_stall", 0, br_stall);
    check_decode("decode_add", enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd5),
                 ALU_ADD, SRC2_RS2, 5'd5, 1'b0, '0, 4'b1000);
    check_decode("decode_sub", enc_r(7'h20, 5'd10, 5'd9, 3'b000, 5'd8),
                 ALU_SUB, SRC2_RS2, 5'd8, 1'b0, '0, 4'b1000);
    check_decode("decode_addi", enc_i(12'hffb, 5'd12, 3'b000, 5'd11, 7'b0010011),
                 ALU_ADD, SRC2_IMM, 5'd11, 1'b1, 64'hffff_ffff_ffff_fffb, 4'b1000);
    check_decode("decode_sltiu", enc_i(12'h7ff, 5'd14, 3'b011, 5'd13, 7'b0010011),
                 ALU_SLTU, SRC2_IMM, 5'd13, 1'b1, 64'h7ff, 4'b1000);
    check_decode("decode_lui", enc_u(20'h80001, 5'd15, 7'b0110111),
                 ALU_PASS_B, SRC2_IMM, 5'd15, 1'b1, 64'hffff_ffff_8000_1000, 4'b1000);
    check_decode("decode_auipc", enc_u(20'h12345, 5'd16, 7'b0010111),
                 ALU_ADD, SRC2_IMM, 5'd16, 1'b1, 64'h1234_5000, 4'b1000);
    check_decode("decode_lw", enc_i(12'hff8, 5'd2, 3'b010, 5'd17, 7'b0000011),
                 ALU_ADD, SRC2_IMM, 5'd17, 1'b1, 64'hffff_ffff_ffff_fff8, 4'b1101);
    check_decode("decode_sd", enc_s(12'h010, 5'd3, 5'd4, 3'b011),
                 ALU_ADD, SRC2_IMM, 5'd0, 1'b1, 64'h10, 4'b0010);
    issue(32'h0000_0fff, 64'h0000_0000_0001_0004); // opcode 1111111
    t = "decode_unknown";
    expect_eq(t, "invalid", 1, invalid);
    expect_eq(t, "enables", 0, 64'({gpr_wen, mem_ren, mem_wen, load}));
    expect_eq(t, "br_taken", 0, br_taken);
  endtask

  task automatic test_gpr_file();
    string t;
    t = "gpr_file";
    for (int r = 1; r <= 6; r++) begin
      write_gpr(5'(r), rand_bits(64));
    end
    write_gpr(5'd0, rand_bits(64)); // dropped by the file
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), 64'h2000);
    expect_eq(t, "rs1_data x1", gpr_model[1], rs1_data);
    expect_eq(t, "rs2_data x2", gpr_model[2], rs2_data);
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd9), 64'h2004);
    expect_eq(t, "rs1_data x3", gpr_model[3], rs1_data);
    expect_eq(t, "rs2_data x4", gpr_model[4], rs2_data);
    issue(enc_r(7'h00, 5'd0, 5'd5, 3'b000, 5'd9), 64'h2008);
    expect_eq(t, "rs1_data x5", gpr_model[5], rs1_data);
    expect_eq(t, "rs2_data x0", 0, rs2_data);
  endtask

  task automatic test_forwarding();
    string t;
    t = "forwarding";
    issue(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd9), 64'h2100);
    tick();
    es_rd     = 5'd5;
    es_result = rand_bits(64);
    ms_rd     = 5'd5;
    ms_result = rand_bits(64);
    ws_rd     = 5'd5;
    ws_result = rand_bits(64);
    #1;
    expect_eq(t, "es over ms and ws", es_result, rs1_data);
    expect_eq(t, "rs2 from file", gpr_model[6], rs2_data);
    tick();
    es_rd = '0;
    #1;
    expect_eq(t, "ms over ws", ms_result, rs1_data);
    tick();
    ms_rd = '0;
    #1;
    expect_eq(t, "ws only", ws_result, rs1_data);
    tick();
    ws_rd = '0;
    #1;
    expect_eq(t, "no match", gpr_model[5], rs1_data);
    // results offered for rd 0 must not reach x0 readers
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9), 64'h2104);
    tick();
    es_result = rand_bits(64) | 64'h1;
    ms_result = rand_bits(64) | 64'h1;
    ws_result = rand_bits(64) | 64'h1;
    #1;
    expect_eq(t, "rd 0 rs1", 0, rs1_data);
    expect_eq(t, "rd 0 rs2", 0, rs2_data);
  endtask

  task automatic test_load_use();
    string t;
    t = "load_use";
    issue(enc_r(7'h00, 5'd8, 5'd7, 3'b000, 5'd1), 64'h3000);
    tick();
    es_load    = 1'b1;
    es_rd      = 5'd7;
    es_allowin = 1'b1;
    fs_valid   = 1'b1; // next instruction waits in fetch
    fs_inst    = enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b0010011);
    fs_pc      = 64'h3004;
    #1;
    expect_eq(t, "rs1 valid", 0, ds_to_es_valid);
    expect_eq(t, "rs1 allowin", 0, ds_allowin);
    tick();
    #1;
    expect_eq(t, "still valid", 0, ds_to_es_valid);
    expect_eq(t, "held pc", 64'h3000, pc);
    tick();
    es_load  = 1'b0;
    fs_valid = 1'b0;
    #1;
    expect_eq(t, "released valid", 1, ds_to_es_valid);
    expect_eq(t, "released allowin", 1, ds_allowin);
    issue(enc_s(12'h000, 5'd9, 5'd10, 3'b011), 64'h3010);
    tick();
    es_load    = 1'b1;
    es_rd      = 5'd9;
    es_allowin = 1'b1;
    #1;
    expect_eq(t, "store rs2 valid", 0, ds_to_es_valid);
    // imm[4:0] of this addi lands in the rs2 field
    issue(enc_i(12'h009, 5'd12, 3'b000, 5'd1, 7'b0010011), 64'h3020);
    tick();
    es_load    = 1'b1;
    es_rd      = 5'd9;
    es_allowin = 1'b1;
    #1;
    expect_eq(t, "itype rs2 valid", 1, ds_to_es_valid);
    expect_eq(t, "itype rs2 allowin", 1, ds_allowin);
    issue(enc_i(12'h000, 5'd0, 3'b000, 5'd1, 7'b0010011), 64'h3030);
    tick();
    es_load    = 1'b1;
    es_rd      = 5'd0;
    es_allowin = 1'b1;
    #1;
    expect_eq(t, "x0 dest valid", 1, ds_to_es_valid);
  endtask

  task automatic test_branches();
    string t;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] bpc;
    t = "branches";
    a = rand_bits(64);
    b = rand_bits(64);
    bpc = 64'h0000_0000_8000_0100;
    write_gpr(5'd20, a);
    write_gpr(5'd21, b);
    check_branch("beq_same", enc_b(13'h1ff0, 5'd20, 5'd20, 3'b000), bpc,
                 1'b1, bpc + sext(64'h1ff0, 13));
    check_branch("beq", enc_b(13'h0040, 5'd21, 5'd20, 3'b000), bpc,
                 a == b, bpc + 64'h40);
    check_branch("bne", enc_b(13'h0008, 5'd21, 5'd20, 3'b001), bpc,
                 a != b, bpc + 64'h8);
    check_branch("blt_ab", enc_b(13'h1800, 5'd21, 5'd20, 3'b100), bpc,
                 $signed(a) < $signed(b), bpc + sext(64'h1800, 13));
    check_branch("blt_ba", enc_b(13'h1800, 5'd20, 5'd21, 3'b100), bpc,
                 $signed(b) < $signed(a), bpc + sext(64'h1800, 13));
    check_branch("bgeu", enc_b(13'h0ffe, 5'd21, 5'd20, 3'b111), bpc,
                 !(a < b), bpc + 64'h0ffe);
    check_branch("jal", enc_j(21'h1fff00, 5'd1), bpc, 1'b1, bpc + sext(64'h1fff00, 21));
    check_branch("jalr", enc_i(12'h7ff, 5'd20, 3'b000, 5'd1, 7'b1100111), bpc,
                 1'b1, (a + 64'h7ff) & ~64'h1);
    issue(enc_b(13'h0010, 5'd20, 5'd20, 3'b000), bpc);
    tick();
    es_load = 1'b1;
    es_rd   = 5'd20;
    #1;
    expect_eq(t, "taken stall br_taken", 1, br_taken);
    expect_eq(t, "taken stall br_stall", 1, br_stall);
    issue(enc_b(13'h0010, 5'd20, 5'd20, 3'b001), bpc);
    tick();
    es_load = 1'b1;
    es_rd   = 5'd20;
    #1;
    expect_eq(t, "not taken br_taken", 0, br_taken);
    expect_eq(t, "not taken br_stall", 0, br_stall);
  endtask

  task automatic test_back_pressure();
    string t;
    t = "back_pressure";
    issue(enc_i(12'd100, 5'd4, 3'b000, 5'd3, 7'b0010011), 64'h4000);
    tick();
    fs_valid   = 1'b1;
    fs_inst    = enc_u(20'habcde, 5'd7, 7'b0110111);
    fs_pc      = 64'h4004;
    es_allowin = 1'b0;
    for (int i = 0; i < 3; i++) begin
      #1;
      expect_eq(t, "ds_allowin", 0, ds_allowin);
      expect_eq(t, "ds_to_es_valid", 1, ds_to_es_valid);
      expect_eq(t, "held pc", 64'h4000, pc);
      expect_eq(t, "held imm", 64'd100, imm);
      expect_eq(t, "held rd", 3, rd);
      tick();
    end
    es_allowin = 1'b1;
    #1;
    expect_eq(t, "reopened allowin", 1, ds_allowin);
    tick();
    fs_valid = 1'b0;
    #1;
    expect_eq(t, "new pc", 64'h4004, pc);
    expect_eq(t, "new imm", 64'hffff_ffff_abcd_e000, imm);
    expect_eq(t, "new rd", 7, rd);
  endtask

  initial begin
    foreach (gpr_model[i]) gpr_model[i] = '0;
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_inst    = '0;
    fs_pc      = '0;
    es_allowin = 1'b0;
    wb_wen     = 1'b0;
    wb_addr    = '0;
    wb_data    = '0;
    es_rd      = '0;
    es_result  = '0;
    ms_rd      = '0;
    ms_result  = '0;
    ws_rd      = '0;
    ws_result  = '0;
    es_load    = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #1;
    test_reset_decode();
    test_gpr_file();
    test_forwarding();
    test_load_use();
    test_branches();
    test_back_pressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- id_stage.f
id_pkg.sv
gpr_file.sv
operand_fwd.sv
inst_decoder.sv
id_stage_ctrl.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - id_pkg.sv
  - gpr_file.sv
  - operand_fwd.sv
  - inst_decoder.sv
  - id_stage_ctrl.sv
  - branch_unit.sv
  - id_stage.sv
  - target: simulation
    files:
      - tb_id_stage.sv
